//--- hw/deflect_tree_top.sv
`default_nettype none

`include "tree_defines.svh"

module deflect_tree_top
	import packet_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire packet_t pe_pkt_i [`NUM_LEAVES],
	output packet_t pe_pkt_o [`NUM_LEAVES],
	output logic [`NUM_LEAVES-1:0] resend_o
);

	// dn_* runs from parent to child, up_* from child to parent
	packet_t dn_mid [2];
	packet_t up_mid [2];
	packet_t dn_bot [4];
	packet_t up_bot [4];
	packet_t dn_leaf [`NUM_LEAVES];
	packet_t up_leaf [`NUM_LEAVES];

	// root has no parent link
	tree_switch #(
		.level(0),
		.node_addr('0)
	) i_root (
		.clk(clk),
		.reset(reset),
		.l_pkt_i(up_mid[0]),
		.r_pkt_i(up_mid[1]),
		.u_pkt_i(PKT_IDLE),
		.l_pkt_o(dn_mid[0]),
		.r_pkt_o(dn_mid[1]),
		.u_pkt_o()
	);

	genvar n;
	generate
		for (n = 0; n < 2; n++) begin : g_mid
			tree_switch #(
				.level(1),
				.node_addr(leaf_addr_t'(n))
			) i_switch (
				.clk(clk),
				.reset(reset),
				.l_pkt_i(up_bot[2*n]),
				.r_pkt_i(up_bot[2*n+1]),
				.u_pkt_i(dn_mid[n]),
				.l_pkt_o(dn_bot[2*n]),
				.r_pkt_o(dn_bot[2*n+1]),
				.u_pkt_o(up_mid[n])
			);
		end

		// each bottom switch serves two neighbouring leaves
		for (n = 0; n < 4; n++) begin : g_bot
			tree_switch #(
				.level(2),
				.node_addr(leaf_addr_t'(n))
			) i_switch (
				.clk(clk),
				.reset(reset),
				.l_pkt_i(up_leaf[2*n]),
				.r_pkt_i(up_leaf[2*n+1]),
				.u_pkt_i(dn_bot[n]),
				.l_pkt_o(dn_leaf[2*n]),
				.r_pkt_o(dn_leaf[2*n+1]),
				.u_pkt_o(up_bot[n])
			);
		end

		for (n = 0; n < `NUM_LEAVES; n++) begin : g_leaf
			leaf_port #(
				.leaf_addr(leaf_addr_t'(n))
			) i_leaf_port (
				.clk(clk),
				.reset(reset),
				.bus_i(dn_leaf[n]),
				.pe_pkt_i(pe_pkt_i[n]),
				.bus_o(up_leaf[n]),
				.pe_pkt_o(pe_pkt_o[n]),
				.resend_o(resend_o[n])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- hw/leaf_port.sv
`default_nettype none

module leaf_port
	import packet_pkg::*;
#(
	parameter leaf_addr_t leaf_addr = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire packet_t bus_i,
	input wire packet_t pe_pkt_i,
	output packet_t bus_o,
	output packet_t pe_pkt_o,
	output logic resend_o
);

	logic accept;
	logic foreign;

	assign accept = pkt_valid(bus_i) && (pkt_dest(bus_i) == leaf_addr);
	assign foreign = pkt_valid(bus_i) && (pkt_dest(bus_i) != leaf_addr);

	// uplink is busy bouncing a deflected packet, PE must retry
	assign resend_o = foreign;

	always_ff @(posedge clk) begin
		if (reset) begin
			bus_o <= PKT_IDLE;
			pe_pkt_o <= PKT_IDLE;
		end else begin
			pe_pkt_o <= accept ? bus_i : PKT_IDLE;
			// no buffer here, a misdelivered packet goes straight back up
			bus_o <= foreign ? bus_i : pe_pkt_i;
		end
	end

endmodule

`default_nettype wire

//--- hw/packet_pkg.sv
`default_nettype none

`include "tree_defines.svh"

package packet_pkg;

	typedef logic [`ADDR_W-1:0] leaf_addr_t;
	typedef logic [`PAYLOAD_W-1:0] payload_t;
	typedef logic [`PACKET_W-1:0] packet_t;

	// all zero is an empty slot on a link
	localparam packet_t PKT_IDLE = '0;

	function automatic logic pkt_valid(packet_t pkt);
		return pkt[`VALID_BIT];
	endfunction

	function automatic leaf_addr_t pkt_dest(packet_t pkt);
		return pkt[`VALID_BIT-1 -: `ADDR_W];
	endfunction

	function automatic payload_t pkt_payload(packet_t pkt);
		return pkt[`PAYLOAD_W-1:0];
	endfunction

endpackage

`default_nettype wire

//--- hw/route_arbiter.sv
`default_nettype none

module route_arbiter
	import route_pkg::*;
#(
	parameter int level = 1
) (
	input wire route_dir_t d_l_i,
	input wire route_dir_t d_r_i,
	input wire route_dir_t d_u_i,
	output route_dir_t sel_l_o,
	output route_dir_t sel_r_o,
	output route_dir_t sel_u_o
);

	generate
		if (level == 0) begin : g_root
			// root has no parent, only the two downlinks are shared
			always_comb begin
				sel_l_o = DIR_VOID;
				sel_r_o = DIR_VOID;
				sel_u_o = DIR_VOID;
				if (d_l_i == DIR_LEFT)
					sel_l_o = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r_o = DIR_RIGHT;
				if (d_r_i == DIR_LEFT) begin
					// right packet crosses over, or bounces back if left is taken
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_RIGHT;
					else
						sel_r_o = DIR_RIGHT;
				end
				if (d_l_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_LEFT;
					else
						sel_l_o = DIR_LEFT;
				end
			end
		end else begin : g_inner
			always_comb begin
				sel_l_o = DIR_VOID;
				sel_r_o = DIR_VOID;
				sel_u_o = DIR_VOID;

				// turnback packets go straight back where they came from
				if (d_l_i == DIR_LEFT)
					sel_l_o = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r_o = DIR_RIGHT;
				if (d_u_i == DIR_UP)
					sel_u_o = DIR_UP;

				// downlink from the parent, pushed back up when blocked
				if (d_u_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_UP;
					else
						sel_u_o = DIR_UP;
				end else if (d_u_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_UP;
					else
						sel_u_o = DIR_UP;
				end

				// left child packet, side link or uplink
				if (d_l_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_LEFT;
					else if (sel_u_o == DIR_VOID)
						sel_u_o = DIR_LEFT;
					else
						sel_l_o = DIR_LEFT;
				end else if (d_l_i == DIR_UP) begin
					if (sel_u_o == DIR_VOID)
						sel_u_o = DIR_LEFT;
					else if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_LEFT;
					else
						sel_r_o = DIR_LEFT;
				end

				// right child packet takes whatever is still free
				if (d_r_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_RIGHT;
					else if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_RIGHT;
					else
						sel_u_o = DIR_RIGHT;
				end else if (d_r_i == DIR_UP) begin
					if (sel_u_o == DIR_VOID)
						sel_u_o = DIR_RIGHT;
					else if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_RIGHT;
					else
						sel_l_o = DIR_RIGHT;
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- hw/route_pkg.sv
`default_nettype none

`include "tree_defines.svh"

package route_pkg;

	import packet_pkg::*;

	// wanted direction of a packet, or the input port feeding an output
	typedef enum logic [1:0] {
		DIR_VOID  = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_RIGHT = 2'b10,
		DIR_UP    = 2'b11
	} route_dir_t;

	// node_addr is right aligned and holds level bits
	function automatic route_dir_t route_decide(packet_t pkt, int level, leaf_addr_t node_addr);
		leaf_addr_t dest;
		leaf_addr_t prefix;
		dest = pkt_dest(pkt);
		// shifts out everything at level 0, so the root always sends down
		prefix = dest >> (`ADDR_W - level);
		if (!pkt_valid(pkt))
			return DIR_VOID;
		if (prefix != node_addr)
			return DIR_UP;
		// next address bit picks the subtree
		return dest[`ADDR_W-1-level] ? DIR_RIGHT : DIR_LEFT;
	endfunction

endpackage

`default_nettype wire

//--- hw/tree_defines.svh
`ifndef TREE_DEFINES_SVH
`define TREE_DEFINES_SVH

// eight leaves, three tree levels above them
`define NUM_LEAVES 8
`define ADDR_W 3

// payload carries four bits more than the address
`define PAYLOAD_W (`ADDR_W + 4)

// valid bit, destination, payload from top to bottom
`define PACKET_W (1 + `ADDR_W + `PAYLOAD_W)
`define VALID_BIT (`PACKET_W - 1)

`endif

//--- hw/tree_switch.sv
`default_nettype none

module tree_switch
	import packet_pkg::*;
	import route_pkg::*;
#(
	parameter int level = 0,
	parameter leaf_addr_t node_addr = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire packet_t l_pkt_i,
	input wire packet_t r_pkt_i,
	input wire packet_t u_pkt_i,
	output packet_t l_pkt_o,
	output packet_t r_pkt_o,
	output packet_t u_pkt_o
);

	route_dir_t d_l;
	route_dir_t d_r;
	route_dir_t d_u;
	route_dir_t sel_l;
	route_dir_t sel_r;
	route_dir_t sel_u;
	packet_t l_next;
	packet_t r_next;
	packet_t u_next;

	// output mux, a void select sends idle
	function automatic packet_t pick(route_dir_t sel, packet_t l, packet_t r, packet_t u);
		case (sel)
			DIR_LEFT: return l;
			DIR_RIGHT: return r;
			DIR_UP: return u;
			default: return PKT_IDLE;
		endcase
	endfunction

	assign d_l = route_decide(l_pkt_i, level, node_addr);
	assign d_r = route_decide(r_pkt_i, level, node_addr);
	assign d_u = route_decide(u_pkt_i, level, node_addr);

	route_arbiter #(
		.level(level)
	) i_route_arbiter (
		.d_l_i(d_l),
		.d_r_i(d_r),
		.d_u_i(d_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	assign l_next = pick(sel_l, l_pkt_i, r_pkt_i, u_pkt_i);
	assign r_next = pick(sel_r, l_pkt_i, r_pkt_i, u_pkt_i);
	assign u_next = pick(sel_u, l_pkt_i, r_pkt_i, u_pkt_i);

	// one hop per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			l_pkt_o <= PKT_IDLE;
			r_pkt_o <= PKT_IDLE;
			u_pkt_o <= PKT_IDLE;
		end else begin
			l_pkt_o <= l_next;
			r_pkt_o <= r_next;
			u_pkt_o <= u_next;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	-f sources.f --top-module tree_tb

output=$(./obj_dir/Vtree_tb || true)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

//--- sources.f
+incdir+hw
hw/packet_pkg.sv
hw/route_pkg.sv
hw/route_arbiter.sv
hw/tree_switch.sv
hw/leaf_port.sv
hw/deflect_tree_top.sv
testbench/tree_tb.sv

//--- testbench/tree_input.txt
# name source_leaf dest_leaf payload_hex mode
# single runs alone and checks latency, burst and resend lines with one name form a group
same_bottom_0_1 0 1 01 single
same_bottom_3_2 3 2 02 single
same_bottom_6_7 6 7 03 single
self_0 0 0 04 single
self_5 5 5 05 single
self_7 7 7 06 single
same_mid_0_3 0 3 07 single
same_mid_2_1 2 1 08 single
same_mid_4_6 4 6 09 single
same_mid_7_5 7 5 0a single
cross_root_0_7 0 7 0b single
cross_root_1_4 1 4 0c single
cross_root_6_2 6 2 0d single
cross_root_5_0 5 0 0e single
cross_root_3_6 3 6 0f single
payload_full 2 5 7f single
burst_mixed 0 7 20 burst
burst_mixed 1 6 21 burst
burst_mixed 2 5 22 burst
burst_mixed 3 4 23 burst
burst_mixed 4 3 24 burst
burst_mixed 5 2 25 burst
burst_mixed 6 1 26 burst
burst_mixed 7 0 27 burst
burst_mixed 0 4 28 burst
burst_mixed 2 2 29 burst
burst_mixed 5 1 2a burst
burst_mixed 7 6 2b burst
burst_hotspot 0 3 30 burst
burst_hotspot 1 3 31 burst
burst_hotspot 2 3 32 burst
burst_hotspot 3 3 33 burst
burst_hotspot 4 3 34 burst
burst_hotspot 5 3 35 burst
burst_hotspot 6 3 36 burst
burst_hotspot 7 3 37 burst
resend_bounce 0 6 40 resend
resend_bounce 1 7 41 resend
resend_bounce 1 2 42 resend

//--- testbench/tree_tb.sv
`default_nettype none

`include "tree_defines.svh"

module tree_tb
	import packet_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES = 5;
	localparam int DELIVERY_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 500;
	// leaf up to its bottom switch and straight back down
	localparam int BOUNCE_CYCLES = 2;
	localparam int MAX_GROUP = 64;
	localparam int NUM_TAGS = 2 ** `PAYLOAD_W;

	typedef logic [8*32-1:0] text_t;

	logic clk;
	logic reset;
	packet_t pe_in [`NUM_LEAVES];
	packet_t pe_out [`NUM_LEAVES];
	logic [`NUM_LEAVES-1:0] resend;

	text_t rec_name [$];
	text_t rec_mode [$];
	leaf_addr_t rec_src [$];
	leaf_addr_t rec_dst [$];
	payload_t rec_payload [$];

	// scoreboard indexed by payload tag
	leaf_addr_t sb_dest [NUM_TAGS];
	logic sb_pending [NUM_TAGS];
	int sb_count;

	deflect_tree_top i_deflect_tree_top (
		.clk(clk),
		.reset(reset),
		.pe_pkt_i(pe_in),
		.pe_pkt_o(pe_out),
		.resend_o(resend)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input string what, input int expected,
			input int actual);
		if (expected != actual)
			stop_with_error($sformatf("FAILED %s: %s expected 0x%0h, actual 0x%0h",
				test, what, expected, actual));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// valid bit on top, then destination, then payload
	function automatic packet_t make_packet(leaf_addr_t dst, payload_t payload);
		return {1'b1, dst, payload};
	endfunction

	// two leaf registers plus one switch per hop up and down
	function automatic int expected_latency(leaf_addr_t src, leaf_addr_t dst);
		if (src[2:1] == dst[2:1])
			return 3;
		if (src[2] == dst[2])
			return 5;
		return 7;
	endfunction

	task automatic check_idle(input string test, input int cycles);
		int c;
		int leaf;
		for (c = 0; c < cycles; c++) begin
			next_cycle();
			for (leaf = 0; leaf < `NUM_LEAVES; leaf++) begin
				check_value(test, $sformatf("pe_pkt_o[%0d]", leaf), 0, int'(pe_out[leaf]));
				check_value(test, $sformatf("resend_o[%0d]", leaf), 0, int'(resend[leaf]));
			end
		end
	endtask

	task automatic load_records();
		int fd;
		int code;
		int src;
		int dst;
		int payload;
		text_t word;
		text_t mode;
		logic [8*200-1:0] rest;
		fd = $fopen("testbench/tree_input.txt", "r");
		if (fd == 0) begin
			stop_with_error("could not open testbench/tree_input.txt");
		end else begin
			code = $fscanf(fd, "%s", word);
			while (code == 1) begin
				if (word == text_t'("#")) begin
					// skip the rest of a comment line
					code = $fgets(rest, fd);
				end else begin
					code = $fscanf(fd, "%d %d %h %s", src, dst, payload, mode);
					if (code != 4)
						stop_with_error($sformatf("bad record for test %0s", word));
					rec_name.push_back(word);
					rec_mode.push_back(mode);
					rec_src.push_back(leaf_addr_t'(src));
					rec_dst.push_back(leaf_addr_t'(dst));
					rec_payload.push_back(payload_t'(payload));
				end
				code = $fscanf(fd, "%s", word);
			end
			$fclose(fd);
		end
	endtask

	task automatic collect_arrivals(input string test);
		int leaf;
		int tag;
		for (leaf = 0; leaf < `NUM_LEAVES; leaf++) begin
			if (pe_out[leaf][`VALID_BIT]) begin
				tag = int'(pkt_payload(pe_out[leaf]));
				if (!sb_pending[tag])
					stop_with_error($sformatf("test %s: payload 0x%0h arrived at leaf %0d %s",
						test, tag, leaf, "but was not in flight"));
				check_value(test, $sformatf("leaf of payload 0x%0h", tag),
					int'(sb_dest[tag]), leaf);
				sb_pending[tag] = 1'b0;
				sb_count--;
			end
		end
	endtask

	task automatic run_single(input int idx);
		string test;
		packet_t expected;
		int latency;
		int cycles;
		int leaf;
		logic arrived;
		test = $sformatf("%0s", rec_name[idx]);
		expected = make_packet(rec_dst[idx], rec_payload[idx]);
		latency = expected_latency(rec_src[idx], rec_dst[idx]);
		pe_in[rec_src[idx]] = expected;
		cycles = 0;
		arrived = 1'b0;
		while (!arrived && cycles < DELIVERY_TIMEOUT) begin
			next_cycle();
			pe_in[rec_src[idx]] = PKT_IDLE;
			cycles++;
			for (leaf = 0; leaf < `NUM_LEAVES; leaf++) begin
				if (pe_out[leaf][`VALID_BIT]) begin
					check_value(test, "arrival leaf", int'(rec_dst[idx]), leaf);
					check_value(test, "packet", int'(expected), int'(pe_out[leaf]));
					check_value(test, "latency", latency, cycles);
					arrived = 1'b1;
				end
			end
		end
		if (!arrived)
			stop_with_error($sformatf("timeout: packet of test %s never arrived", test));
	endtask

	// bounce holds the last record back until the first deflection reaches its leaf
	task automatic run_group(input int first, input int last, input logic bounce);
		string test;
		logic injected [MAX_GROUP];
		logic busy [`NUM_LEAVES];
		logic bounce_checked;
		int to_inject;
		int cyc;
		int r;
		int leaf;
		leaf_addr_t src;
		test = $sformatf("%0s", rec_name[first]);
		if (last - first > MAX_GROUP)
			stop_with_error($sformatf("test %s has too many records", test));
		for (r = 0; r < MAX_GROUP; r++)
			injected[r] = 1'b0;
		for (r = 0; r < NUM_TAGS; r++)
			sb_pending[r] = 1'b0;
		sb_count = 0;
		to_inject = last - first;
		bounce_checked = 1'b0;
		cyc = 0;
		while ((to_inject > 0 || sb_count > 0) && cyc < DRAIN_TIMEOUT) begin
			for (leaf = 0; leaf < `NUM_LEAVES; leaf++) begin
				pe_in[leaf] = PKT_IDLE;
				busy[leaf] = 1'b0;
			end
			// oldest waiting record of each leaf is offered
			for (r = first; r < last; r++) begin
				src = rec_src[r];
				if (!injected[r-first] && !busy[src] &&
						!(bounce && r == last - 1 && cyc < BOUNCE_CYCLES)) begin
					busy[src] = 1'b1;
					pe_in[src] = make_packet(rec_dst[r], rec_payload[r]);
					if (bounce && r == last - 1 && !bounce_checked) begin
						check_value(test, "resend_o of the offering leaf", 1,
							int'(resend[src]));
						bounce_checked = 1'b1;
					end
					if (!resend[src]) begin
						injected[r-first] = 1'b1;
						sb_dest[rec_payload[r]] = rec_dst[r];
						sb_pending[rec_payload[r]] = 1'b1;
						sb_count++;
						to_inject--;
					end
				end
			end
			next_cycle();
			cyc++;
			collect_arrivals(test);
		end
		if (to_inject > 0 || sb_count > 0)
			stop_with_error($sformatf("timeout: test %s still had %0d %s and %0d in flight",
				test, to_inject, "waiting to inject", sb_count));
	endtask

	initial begin
		int i;
		int j;
		reset = 1'b1;
		for (i = 0; i < `NUM_LEAVES; i++)
			pe_in[i] = PKT_IDLE;
		load_records();
		for (i = 0; i < RESET_CYCLES; i++)
			next_cycle();
		reset = 1'b0;
		check_idle("reset_state", IDLE_CYCLES);
		i = 0;
		while (i < rec_name.size()) begin
			j = i + 1;
			while (j < rec_name.size() && rec_name[j] == rec_name[i])
				j++;
			if (rec_mode[i] == text_t'("single"))
				run_single(i);
			else if (rec_mode[i] == text_t'("burst"))
				run_group(i, j, 1'b0);
			else if (rec_mode[i] == text_t'("resend"))
				run_group(i, j, 1'b1);
			else
				stop_with_error($sformatf("unknown mode in test %0s", rec_name[i]));
			// stray or duplicate packets would show up here
			check_idle($sformatf("%0s", rec_name[i]), IDLE_CYCLES);
			i = j;
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire
